//--- build.f
+incdir+include
source/trace_cfg_pkg.sv
source/trace_fmt_pkg.sv
source/replay_progress_if.sv
source/trace_shift_buf.sv
source/replay_progress.sv
source/unit_assembler.sv
source/trace_replay_parser.sv
sim/tb_trace_replay_parser.sv

//--- Makefile
TOP := tb_trace_replay_parser

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	@if grep -q "TEST RESULT: FAIL" sim.log; then \
		echo "simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "TEST RESULT: PASS" sim.log; then \
		echo "simulation ended without a result"; exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf obj_dir sim.log

//--- include/trace_stream_model.svh
`ifndef TRACE_STREAM_MODEL_SVH
`define TRACE_STREAM_MODEL_SVH

localparam int MODEL_UNITS        = 40;
localparam int MODEL_MIN_LEN      = 16;
localparam int MODEL_OFFSET_WIDTH = $clog2(trace_cfg_pkg::UNIT_WIDTH + 1);

typedef logic [trace_cfg_pkg::UNIT_WIDTH-1:0] model_unit_t;
typedef logic [trace_cfg_pkg::BEAT_WIDTH-1:0] model_beat_t;

logic [31:0]     lcg_state = 32'hcab2;
// expected units in output order with their lengths in bits
model_unit_t     exp_units[$];
int              exp_lens[$];
// packed trace, one entry per input FIFO word
model_beat_t     trace_beats[$];
longint unsigned trace_bits;

function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
endfunction

// random aligned length unless force_len is given, payload cleared above the length
function automatic model_unit_t model_make_unit(input int force_len, output int len);
    model_unit_t unit;
    int          steps;
    steps = (trace_cfg_pkg::UNIT_WIDTH - MODEL_MIN_LEN) / trace_cfg_pkg::ALIGN_WIDTH + 1;
    if (force_len != 0) begin
        len = force_len;
    end else begin
        len = MODEL_MIN_LEN + trace_cfg_pkg::ALIGN_WIDTH * int'((lcg_next() >> 8) % steps);
    end
    for (int i = 0; i < trace_cfg_pkg::UNIT_WIDTH; i += 32) begin
        unit[i +: 32] = lcg_next();
    end
    for (int b = len; b < trace_cfg_pkg::UNIT_WIDTH; b++) begin
        unit[b] = 1'b0;
    end
    unit[0 +: MODEL_OFFSET_WIDTH] = MODEL_OFFSET_WIDTH'(len);
    return unit;
endfunction

// units back to back, the last one sized to end on a beat boundary
function automatic void model_build_trace();
    model_beat_t beat;
    model_unit_t unit;
    int          pos;
    int          len;
    int          force_len;
    beat       = '0;
    pos        = 0;
    trace_bits = 0;
    for (int u = 0; u < MODEL_UNITS; u++) begin
        force_len = 0;
        if (u == MODEL_UNITS - 1) begin
            force_len = trace_cfg_pkg::BEAT_WIDTH - pos;
            if (force_len < MODEL_MIN_LEN) begin
                force_len += trace_cfg_pkg::BEAT_WIDTH;
            end
        end
        unit = model_make_unit(force_len, len);
        exp_units.push_back(unit);
        exp_lens.push_back(len);
        trace_bits += longint'(len);
        for (int b = 0; b < len; b++) begin
            beat[pos] = unit[b];
            pos++;
            if (pos == trace_cfg_pkg::BEAT_WIDTH) begin
                trace_beats.push_back(beat);
                beat = '0;
                pos  = 0;
            end
        end
    end
    if (pos != 0) begin
        trace_beats.push_back(beat);
    end
endfunction

`endif

//--- sim/tb_trace_replay_parser.sv
`timescale 1ns/100ps

module tb_trace_replay_parser;

    `include "trace_stream_model.svh"

    localparam int BEAT_WIDTH   = trace_cfg_pkg::BEAT_WIDTH;
    localparam int UNIT_WIDTH   = trace_cfg_pkg::UNIT_WIDTH;
    localparam int COUNT_WIDTH  = trace_cfg_pkg::COUNT_WIDTH;
    // quiet cycles after the last unit, a stray strobe would show up here
    localparam int DRAIN_CYCLES = 20;

    logic                   clk;
    logic                   sync_rst_n;
    logic [BEAT_WIDTH-1:0]  in_data;
    logic                   in_empty;
    logic                   in_rd_en;
    logic [UNIT_WIDTH-1:0]  out_data;
    logic                   out_wr_en;
    logic                   out_almfull;
    logic [COUNT_WIDTH-1:0] replay_bits;
    logic [COUNT_WIDTH-1:0] rt_replay_bits;

    int          errors;
    // next trace word the input FIFO presents
    int          rd_ptr;
    int          units_seen;
    int          cycles;
    int          cycle_limit;
    // cycle when every unit was out and every beat read, -1 before that
    int          done_cycle;
    logic        fifo_hold;
    logic        rd_taken;
    model_unit_t len_mask;

    trace_replay_parser trace_replay_parser_i (
        .clk            (clk),
        .sync_rst_n     (sync_rst_n),
        .in_data        (in_data),
        .in_empty       (in_empty),
        .in_rd_en       (in_rd_en),
        .out_data       (out_data),
        .out_wr_en      (out_wr_en),
        .out_almfull    (out_almfull),
        .replay_bits    (replay_bits),
        .rt_replay_bits (rt_replay_bits)
    );

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic compare_value(input string name, input logic [UNIT_WIDTH-1:0] expected,
                                 input logic [UNIT_WIDTH-1:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
        end
    endtask

    // input FIFO with first word fall through, randomly starved
    // almost full toggles at random and only throttles reads
    task automatic drive_inputs();
        fifo_hold   = ((lcg_next() >> 12) % 4) == 0;
        out_almfull = ((lcg_next() >> 12) % 5) == 0;
        in_empty    = fifo_hold || (rd_ptr >= trace_beats.size());
        in_data     = in_empty ? '0 : trace_beats[rd_ptr];
    endtask

    initial begin
        errors      = 0;
        rd_ptr      = 0;
        units_seen  = 0;
        cycles      = 0;
        done_cycle  = -1;
        fifo_hold   = 1'b1;
        rd_taken    = 1'b0;
        sync_rst_n  = 1'b0;
        in_data     = '0;
        in_empty    = 1'b1;
        out_almfull = 1'b0;
        replay_bits = '0;

        model_build_trace();
        replay_bits = COUNT_WIDTH'(trace_bits);
        // generous bound on the drain time per beat with throttling
        cycle_limit = 60 * trace_beats.size() + 200;

        repeat (3) @(posedge clk);
        #2;
        sync_rst_n = 1'b1;
        drive_inputs();

        while (cycles < cycle_limit &&
               (done_cycle < 0 || cycles < done_cycle + DRAIN_CYCLES)) begin
            // mid cycle, DUT outputs are settled
            @(negedge clk);
            rd_taken = in_rd_en;
            if (in_rd_en && (in_empty || out_almfull)) begin
                errors++;
                $display("read strobe while input empty or output almost full, cycle %0d",
                    cycles);
            end
            if (out_wr_en) begin
                if (units_seen >= MODEL_UNITS) begin
                    errors++;
                    $display("unit written after the last expected unit, cycle %0d", cycles);
                end else begin
                    // only the unit's own length is defined
                    len_mask = '1;
                    len_mask = len_mask >> (UNIT_WIDTH - exp_lens[units_seen]);
                    compare_value("out_data", exp_units[units_seen], out_data & len_mask);
                    units_seen++;
                end
            end

            @(posedge clk);
            #2;
            // the word taken at this edge leaves the FIFO
            if (rd_taken) begin
                rd_ptr++;
            end
            drive_inputs();
            cycles++;
            if (done_cycle < 0 && units_seen == MODEL_UNITS && rd_ptr == trace_beats.size()) begin
                done_cycle = cycles;
            end
        end

        if (done_cycle < 0) begin
            errors++;
            $display("timeout after %0d cycles, %0d of %0d units out, %0d of %0d beats read",
                cycles, units_seen, MODEL_UNITS, rd_ptr, trace_beats.size());
        end else begin
            // every aligned packet counted once, padding excluded
            compare_value("rt_replay_bits", UNIT_WIDTH'(replay_bits), UNIT_WIDTH'(rt_replay_bits));
        end

        $display("run ended with %0d errors, %0d units checked", errors, units_seen);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- source/trace_replay_parser.sv
`timescale 1ns/100ps

module trace_replay_parser #(
    parameter int BEAT_WIDTH  = trace_cfg_pkg::BEAT_WIDTH,
    parameter int ALIGN_WIDTH = trace_cfg_pkg::ALIGN_WIDTH,
    parameter int UNIT_WIDTH  = trace_cfg_pkg::UNIT_WIDTH,
    parameter int COUNT_WIDTH = trace_cfg_pkg::COUNT_WIDTH
) (
    input  logic                   clk,
    input  logic                   sync_rst_n,
    // input FIFO, first word falls through
    input  logic [BEAT_WIDTH-1:0]  in_data,
    input  logic                   in_empty,
    output logic                   in_rd_en,
    // output FIFO, almost full is the only back-pressure
    output logic [UNIT_WIDTH-1:0]  out_data,
    output logic                   out_wr_en,
    input  logic                   out_almfull,
    // aligned trace total and bits handed to the assembler so far
    input  logic [COUNT_WIDTH-1:0] replay_bits,
    output logic [COUNT_WIDTH-1:0] rt_replay_bits
);
    localparam int OFFSET_WIDTH = $clog2(UNIT_WIDTH + 1);

    if ((UNIT_WIDTH % BEAT_WIDTH) != 0 || (UNIT_WIDTH % ALIGN_WIDTH) != 0 ||
        UNIT_WIDTH <= BEAT_WIDTH) begin : g_bad_cfg
        $error("trace_replay_parser: bad widths beat %0d align %0d unit %0d",
            BEAT_WIDTH, ALIGN_WIDTH, UNIT_WIDTH);
    end

    // stage between shift buffer and assembler
    logic                    beat_valid;
    logic [BEAT_WIDTH-1:0]   beat_data;
    logic [OFFSET_WIDTH-1:0] beat_len;

    replay_progress_if #(
        .ALIGN_WIDTH (ALIGN_WIDTH),
        .UNIT_WIDTH  (UNIT_WIDTH)
    ) prog_if ();

    trace_shift_buf #(
        .BEAT_WIDTH  (BEAT_WIDTH),
        .ALIGN_WIDTH (ALIGN_WIDTH),
        .UNIT_WIDTH  (UNIT_WIDTH)
    ) shift_buf_i (
        .clk         (clk),
        .sync_rst_n  (sync_rst_n),
        .in_data     (in_data),
        .in_empty    (in_empty),
        .out_almfull (out_almfull),
        .in_rd_en    (in_rd_en),
        .beat_valid  (beat_valid),
        .beat_data   (beat_data),
        .beat_len    (beat_len),
        .prog        (prog_if.buf_side)
    );

    replay_progress #(
        .BEAT_WIDTH  (BEAT_WIDTH),
        .ALIGN_WIDTH (ALIGN_WIDTH),
        .UNIT_WIDTH  (UNIT_WIDTH),
        .COUNT_WIDTH (COUNT_WIDTH)
    ) progress_i (
        .clk            (clk),
        .sync_rst_n     (sync_rst_n),
        .replay_bits    (replay_bits),
        .rt_replay_bits (rt_replay_bits),
        .prog           (prog_if.progress_side)
    );

    unit_assembler #(
        .BEAT_WIDTH (BEAT_WIDTH),
        .UNIT_WIDTH (UNIT_WIDTH)
    ) assembler_i (
        .clk        (clk),
        .sync_rst_n (sync_rst_n),
        .beat_valid (beat_valid),
        .beat_data  (beat_data),
        .beat_len   (beat_len),
        .out_data   (out_data),
        .out_wr_en  (out_wr_en)
    );

endmodule

//--- source/unit_assembler.sv
`timescale 1ns/100ps

module unit_assembler #(
    parameter int  BEAT_WIDTH   = trace_cfg_pkg::BEAT_WIDTH,
    parameter int  UNIT_WIDTH   = trace_cfg_pkg::UNIT_WIDTH,
    localparam int OFFSET_WIDTH = $clog2(UNIT_WIDTH + 1)
) (
    input  logic                    clk,
    input  logic                    sync_rst_n,
    input  logic                    beat_valid,
    input  logic [BEAT_WIDTH-1:0]   beat_data,
    input  logic [OFFSET_WIDTH-1:0] beat_len,
    output logic [UNIT_WIDTH-1:0]   out_data,
    output logic                    out_wr_en
);
    localparam int NUM_BEATS = UNIT_WIDTH / BEAT_WIDTH;
    localparam int IDX_WIDTH = $clog2(NUM_BEATS + 1);
    localparam int SEL_WIDTH = $clog2(NUM_BEATS);

    if ((UNIT_WIDTH % BEAT_WIDTH) != 0 || NUM_BEATS < 2) begin : g_bad_cfg
        $error("unit_assembler: unit %0d is not a multiple of beat %0d above one beat",
            UNIT_WIDTH, BEAT_WIDTH);
    end

    trace_fmt_pkg::asm_state_t          asm_state;
    trace_fmt_pkg::asm_state_t          asm_next;
    logic [NUM_BEATS-1:0][BEAT_WIDTH-1:0] unit_data;
    // beats stored so far, valid in WAIT_BODY and DONE
    logic [IDX_WIDTH-1:0]               beat_idx;
    logic [OFFSET_WIDTH-1:0]            unit_len;
    logic [OFFSET_WIDTH-1:0]            covered_len;
    logic                               first_fits;

    // bits held once the incoming body beat is stored
    assign covered_len = OFFSET_WIDTH'((beat_idx + 1'b1) * BEAT_WIDTH);
    assign first_fits  = beat_len <= OFFSET_WIDTH'(BEAT_WIDTH);

    // DONE needs no stall, the read throttle keeps the output FIFO from filling
    always_comb begin
        asm_next = asm_state;
        case (asm_state)
            trace_fmt_pkg::WAIT_BODY: begin
                if (beat_valid && unit_len <= covered_len) begin
                    asm_next = trace_fmt_pkg::DONE;
                end
            end
            default: begin
                // WAIT_HEADER and DONE both take a header
                if (!beat_valid) begin
                    asm_next = trace_fmt_pkg::WAIT_HEADER;
                end else if (first_fits) begin
                    asm_next = trace_fmt_pkg::DONE;
                end else begin
                    asm_next = trace_fmt_pkg::WAIT_BODY;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!sync_rst_n) begin
            asm_state <= trace_fmt_pkg::WAIT_HEADER;
            beat_idx  <= '0;
            unit_len  <= '0;
        end else begin
            asm_state <= asm_next;
            if (asm_state == trace_fmt_pkg::WAIT_BODY) begin
                beat_idx <= beat_idx + IDX_WIDTH'(beat_valid);
            end else if (beat_valid) begin
                // length only rides meaningfully on a header beat
                unit_len <= beat_len;
                beat_idx <= IDX_WIDTH'(1);
            end
        end
    end

    // in DONE the header of the next unit overwrites slot 0 after the write
    always_ff @(posedge clk) begin
        if (beat_valid) begin
            if (asm_state == trace_fmt_pkg::WAIT_BODY) begin
                unit_data[beat_idx[SEL_WIDTH-1:0]] <= beat_data;
            end else begin
                unit_data[0] <= beat_data;
            end
        end
    end

    assign out_data  = unit_data;
    assign out_wr_en = (asm_state == trace_fmt_pkg::DONE);

    // a length field above the widest unit would walk the slot index off the end
    a_idx_in_unit: assert property (@(posedge clk) disable iff (!sync_rst_n)
        (asm_state == trace_fmt_pkg::WAIT_BODY) |->
            (beat_idx < IDX_WIDTH'(NUM_BEATS)))
        else $error("beat index reached the unit beat count");

endmodule

//--- source/replay_progress.sv
`timescale 1ns/100ps

module replay_progress #(
    parameter int BEAT_WIDTH  = trace_cfg_pkg::BEAT_WIDTH,
    parameter int ALIGN_WIDTH = trace_cfg_pkg::ALIGN_WIDTH,
    parameter int UNIT_WIDTH  = trace_cfg_pkg::UNIT_WIDTH,
    parameter int COUNT_WIDTH = trace_cfg_pkg::COUNT_WIDTH
) (
    input  logic                     clk,
    input  logic                     sync_rst_n,
    input  logic [COUNT_WIDTH-1:0]   replay_bits,
    output logic [COUNT_WIDTH-1:0]   rt_replay_bits,
    replay_progress_if.progress_side prog
);
    localparam int BEAT_BITS      = $clog2(BEAT_WIDTH);
    localparam int ALIGN_BITS     = $clog2(ALIGN_WIDTH);
    localparam int LEN_WIDTH      = $clog2(UNIT_WIDTH + 1) - ALIGN_BITS;
    localparam int BEAT_ALIGNED   = BEAT_WIDTH / ALIGN_WIDTH;
    localparam int BEAT_CNT_WIDTH = COUNT_WIDTH - BEAT_BITS;
    localparam int PKT_CNT_WIDTH  = COUNT_WIDTH - ALIGN_BITS;

    if ((BEAT_WIDTH % ALIGN_WIDTH) != 0 || UNIT_WIDTH <= BEAT_WIDTH ||
        COUNT_WIDTH <= BEAT_BITS) begin : g_bad_cfg
        $error("replay_progress: bad widths beat %0d align %0d count %0d",
            BEAT_WIDTH, ALIGN_WIDTH, COUNT_WIDTH);
    end

    logic [COUNT_WIDTH-1:0]    bits_ceil;
    logic [BEAT_CNT_WIDTH-1:0] beat_total;
    logic [BEAT_CNT_WIDTH-1:0] beat_cnt;
    logic [PKT_CNT_WIDTH-1:0]  pkt_cnt;
    logic [LEN_WIDTH-1:0]      pkt_add;

    // whole beats that hold the trace, the last one partly zero
    assign bits_ceil  = replay_bits + COUNT_WIDTH'(BEAT_WIDTH - 1);
    assign beat_total = bits_ceil[COUNT_WIDTH-1:BEAT_BITS];

    // pad beats count too, so the count moves past the total after one pad
    always_ff @(posedge clk) begin
        if (!sync_rst_n) begin
            beat_cnt <= '0;
        end else if (prog.hi_load || prog.pad_last) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    // one zero beat pushes the tail of the last unit out of LO
    assign prog.pad_last = (beat_cnt != '0) && (beat_cnt == beat_total) && prog.hi_free;

    // addend is registered to keep the adder off the LO send path
    always_ff @(posedge clk) begin
        if (!sync_rst_n) begin
            pkt_cnt <= '0;
            pkt_add <= '0;
        end else begin
            pkt_cnt <= pkt_cnt + PKT_CNT_WIDTH'(pkt_add);
            if (prog.lo_out && !prog.replay_done) begin
                pkt_add <= prog.lo_satisfied ? prog.lo_remain_len : LEN_WIDTH'(BEAT_ALIGNED);
            end else begin
                pkt_add <= '0;
            end
        end
    end

    // counts the addend in flight, so the next send after the last packet is blocked
    assign prog.replay_done = replay_bits[COUNT_WIDTH-1:ALIGN_BITS] ==
                              (pkt_cnt + PKT_CNT_WIDTH'(pkt_add));

    assign rt_replay_bits = {pkt_cnt, {ALIGN_BITS{1'b0}}};

    a_pad_not_with_read: assert property (@(posedge clk) disable iff (!sync_rst_n)
        !(prog.pad_last && prog.hi_load))
        else $error("zero pad and trace read in the same cycle");

endmodule

//--- source/trace_shift_buf.sv
`timescale 1ns/100ps

module trace_shift_buf #(
    parameter int  BEAT_WIDTH   = trace_cfg_pkg::BEAT_WIDTH,
    parameter int  ALIGN_WIDTH  = trace_cfg_pkg::ALIGN_WIDTH,
    parameter int  UNIT_WIDTH   = trace_cfg_pkg::UNIT_WIDTH,
    localparam int OFFSET_WIDTH = $clog2(UNIT_WIDTH + 1)
) (
    input  logic                    clk,
    input  logic                    sync_rst_n,
    input  logic [BEAT_WIDTH-1:0]   in_data,
    input  logic                    in_empty,
    input  logic                    out_almfull,
    output logic                    in_rd_en,
    output logic                    beat_valid,
    output logic [BEAT_WIDTH-1:0]   beat_data,
    output logic [OFFSET_WIDTH-1:0] beat_len,
    replay_progress_if.buf_side     prog
);
    localparam int ALIGN_BITS   = $clog2(ALIGN_WIDTH);
    localparam int LEN_WIDTH    = OFFSET_WIDTH - ALIGN_BITS;
    // aligned words per beat and the offset that walks them inside LO
    localparam int BEAT_ALIGNED = BEAT_WIDTH / ALIGN_WIDTH;
    localparam int OFF_WIDTH    = $clog2(BEAT_ALIGNED);
    // room for remain plus offset without wrapping
    localparam int EXH_WIDTH    = LEN_WIDTH + OFF_WIDTH;

    if ((UNIT_WIDTH % BEAT_WIDTH) != 0 || (BEAT_WIDTH % ALIGN_WIDTH) != 0 ||
        UNIT_WIDTH <= BEAT_WIDTH || BEAT_WIDTH <= ALIGN_WIDTH ||
        ALIGN_WIDTH != (1 << ALIGN_BITS) || BEAT_WIDTH != (1 << $clog2(BEAT_WIDTH))) begin : g_bad_cfg
        $error("trace_shift_buf: bad widths beat %0d align %0d unit %0d",
            BEAT_WIDTH, ALIGN_WIDTH, UNIT_WIDTH);
    end

    // [BEAT_WIDTH +: BEAT_WIDTH] is HI, [0 +: BEAT_WIDTH] is LO
    logic [2*BEAT_WIDTH-1:0]         shift_buf;
    logic                            hi_full;
    logic                            hi_lo_shift;
    trace_fmt_pkg::lo_state_t        lo_state;
    logic                            lo_empty;
    logic                            lo_out;
    logic                            lo_exhaust;
    logic                            lo_satisfied;
    logic [OFF_WIDTH-1:0]            lo_off;
    logic [OFF_WIDTH+ALIGN_BITS-1:0] lo_shamt;
    logic [BEAT_WIDTH-1:0]           lo_out_data;
    logic [LEN_WIDTH-1:0]            lo_remain_len;
    logic [LEN_WIDTH-1:0]            lo_remain_reg;

    // a beat is only pulled when HI is free now or empties into LO this cycle
    assign in_rd_en = !in_empty && !out_almfull && (!hi_full || hi_lo_shift);

    // HI state machine, loaded by a read or by the end of trace zero pad
    always_ff @(posedge clk) begin
        if (!sync_rst_n) begin
            hi_full <= 1'b0;
        end else if (in_rd_en || prog.pad_last) begin
            hi_full <= 1'b1;
        end else if (hi_lo_shift) begin
            hi_full <= 1'b0;
        end
    end

    // LO only sends while HI holds the continuation of its data
    assign lo_empty = (lo_state == trace_fmt_pkg::EMPTY);
    assign lo_out   = hi_full && !lo_empty;

    // window of one beat starting at the current unit position
    assign lo_shamt    = {lo_off, {ALIGN_BITS{1'b0}}};
    assign lo_out_data = shift_buf[lo_shamt +: BEAT_WIDTH];

    // header state decodes the length, body state uses what is left of it
    always_comb begin
        case (lo_state)
            trace_fmt_pkg::HEADER:
                lo_remain_len = lo_out_data[trace_fmt_pkg::HEADER_LSB + ALIGN_BITS +: LEN_WIDTH];
            trace_fmt_pkg::BODY:
                lo_remain_len = lo_remain_reg;
            default:
                lo_remain_len = '0;
        endcase
    end

    // LO is used up once the unit reaches or crosses its top
    assign lo_exhaust = (EXH_WIDTH'(lo_remain_len) + EXH_WIDTH'(lo_off)) >=
                        EXH_WIDTH'(BEAT_ALIGNED);
    // this beat carries the tail of the unit
    assign lo_satisfied = lo_remain_len <= LEN_WIDTH'(BEAT_ALIGNED);
    assign hi_lo_shift  = hi_full && (lo_empty || (lo_out && lo_exhaust));

    // LO state machine
    // a satisfied send always lands on the next header, offset wraps mod a beat
    always_ff @(posedge clk) begin
        if (!sync_rst_n) begin
            lo_state <= trace_fmt_pkg::EMPTY;
            lo_off   <= '0;
        end else if (lo_empty) begin
            if (hi_lo_shift) begin
                lo_state <= trace_fmt_pkg::HEADER;
            end
        end else if (lo_out && lo_satisfied) begin
            lo_state <= trace_fmt_pkg::HEADER;
            lo_off   <= lo_off + lo_remain_len[OFF_WIDTH-1:0];
        end else if (lo_out) begin
            // not satisfied means exhausted, HI moves down and the unit goes on
            lo_state <= trace_fmt_pkg::BODY;
        end
    end

    // only read back in BODY, which always follows a write here
    always_ff @(posedge clk) begin
        if (lo_out && !lo_satisfied) begin
            lo_remain_reg <= lo_remain_len - LEN_WIDTH'(BEAT_ALIGNED);
        end
    end

    always_ff @(posedge clk) begin
        if (in_rd_en) begin
            shift_buf[BEAT_WIDTH +: BEAT_WIDTH] <= in_data;
        end else if (prog.pad_last) begin
            shift_buf[BEAT_WIDTH +: BEAT_WIDTH] <= '0;
        end
        if (hi_lo_shift) begin
            shift_buf[0 +: BEAT_WIDTH] <= shift_buf[BEAT_WIDTH +: BEAT_WIDTH];
        end
    end

    assign prog.hi_load       = in_rd_en;
    assign prog.hi_free       = !hi_full || hi_lo_shift;
    assign prog.lo_out        = lo_out;
    assign prog.lo_satisfied  = lo_satisfied;
    assign prog.lo_remain_len = lo_remain_len;

    // register barrier toward the assembler
    // trailing padding is dropped once every aligned packet went out
    always_ff @(posedge clk) begin
        if (!sync_rst_n) begin
            beat_valid <= 1'b0;
        end else begin
            beat_valid <= lo_out && !prog.replay_done;
        end
    end

    always_ff @(posedge clk) begin
        beat_data <= lo_out_data;
        beat_len  <= {lo_remain_len, {ALIGN_BITS{1'b0}}};
    end

    // the pad request comes from the progress counter and needs room in HI
    a_hi_no_overwrite: assert property (@(posedge clk) disable iff (!sync_rst_n)
        prog.pad_last |-> (!hi_full || hi_lo_shift))
        else $error("HI loaded while full and not shifting");

endmodule

//--- source/replay_progress_if.sv
`timescale 1ns/100ps

interface replay_progress_if #(
    parameter int ALIGN_WIDTH = trace_cfg_pkg::ALIGN_WIDTH,
    parameter int UNIT_WIDTH  = trace_cfg_pkg::UNIT_WIDTH
);
    // unit length counted in alignment units
    localparam int LEN_WIDTH = $clog2(UNIT_WIDTH + 1) - $clog2(ALIGN_WIDTH);

    // shift buffer side
    logic                 hi_load;
    logic                 hi_free;
    logic                 lo_out;
    logic                 lo_satisfied;
    logic [LEN_WIDTH-1:0] lo_remain_len;

    // progress side
    logic                 pad_last;
    logic                 replay_done;

    modport buf_side (
        output hi_load, hi_free, lo_out, lo_satisfied, lo_remain_len,
        input  pad_last, replay_done
    );

    modport progress_side (
        input  hi_load, hi_free, lo_out, lo_satisfied, lo_remain_len,
        output pad_last, replay_done
    );

endinterface

//--- source/trace_fmt_pkg.sv
package trace_fmt_pkg;

    // LO half of the shift buffer
    // EMPTY only until the first beat moves down from HI
    typedef enum logic [1:0] {
        EMPTY,
        HEADER,
        BODY
    } lo_state_t;

    // assembler, DONE is the cycle the unit is written out
    typedef enum logic [1:0] {
        WAIT_HEADER,
        WAIT_BODY,
        DONE
    } asm_state_t;

    // length field of a unit sits at the bottom of its first aligned word
    // the field holds the unit length in bits, low alignment bits are zero
    localparam int HEADER_LSB = 0;

endpackage

//--- source/trace_cfg_pkg.sv
package trace_cfg_pkg;

    // bits per input beat read from the trace FIFO
    localparam int BEAT_WIDTH = 64;

    // every logging unit starts on a multiple of this
    localparam int ALIGN_WIDTH = 8;

    // widest logging unit, multiple of both beat and alignment, longer than a beat
    localparam int UNIT_WIDTH = 256;

    // width of the replay bit totals and the progress report
    localparam int COUNT_WIDTH = 64;

endpackage
